// ==== width_down_input.txt ====
# B test addr len size           burst command, test number in decimal, rest in hex
# D wdata wstrb ndata nstrb      one beat, wide input then expected narrow output
B 2 00001000 01 2
D DEADBEEF44332211 0f 44332211 f
D 88776655DEADBEEF f0 88776655 f
B 2 00002004 02 2
D A3A2A1A0CAFEF00D f0 A3A2A1A0 f
D CAFEF00DB3B2B1B0 0f B3B2B1B0 f
D C3C2C1C0CAFEF00D 50 C3C2C1C0 5
B 3 00003003 03 0
D FFFFFFFF11FFFFFF 08 11000000 8
D FFFFFF22FFFFFFFF 10 00000022 1
D FFFF33FFFFFFFFFF 20 00003300 2
D FF44FFFFFFFFFFFF 40 00440000 4
B 3 00004005 02 1
D 11BBAA1111111111 60 00BBAA00 6
D DDCC111111111111 c0 DDCC0000 c
D 111111111111FFEE 03 0000FFEE 3
B 4 00005002 00 1
D 1234567899887766 0c 99880000 c
B 4 00006000 03 2
D 0123456789ABCDEF 0f 89ABCDEF f
D 0123456789ABCDEF f0 01234567 f
D FEDCBA9876543210 0f 76543210 f
D FEDCBA9876543210 f0 FEDCBA98 f
B 5 00007000 07 2
D A0000000B0000000 0f B0000000 f
D A0000001B0000001 f0 A0000001 f
D A0000002B0000002 0f B0000002 f
D A0000003B0000003 f0 A0000003 f
D A0000004B0000004 0f B0000004 f
D A0000005B0000005 f0 A0000005 f
D A0000006B0000006 0f B0000006 f
D A0000007B0000007 f0 A0000007 f

// ==== verilog.f ====
width_pkg.sv
width_if.sv
burst_accept.sv
beat_fifo.sv
lane_steer.sv
width_down_top.sv
tb_width_down.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f verilog.f --top-module width_down_top

sim:
	verilator --binary --timing --assert -f verilog.f --top-module tb_width_down -o sim_tb
	./obj_dir/sim_tb > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_width_down.sv ====
module tb_width_down;

  logic        clk_i;
  logic        rst_ni;
  logic        s_aw_valid;
  logic        s_aw_ready;
  logic [31:0] s_aw_addr;
  logic [7:0]  s_aw_len;
  logic [2:0]  s_aw_size;
  logic        s_w_valid;
  logic        s_w_ready;
  logic [63:0] s_w_data;
  logic [7:0]  s_w_strb;
  logic        s_w_last;
  logic        m_aw_valid;
  logic        m_aw_ready;
  logic [31:0] m_aw_addr;
  logic [7:0]  m_aw_len;
  logic [2:0]  m_aw_size;
  logic        m_w_valid;
  logic        m_w_ready;
  logic [31:0] m_w_data;
  logic [3:0]  m_w_strb;
  logic        m_w_last;

  // Bursts and beats loaded from the data file
  int          burst_test [32];
  logic [31:0] burst_addr [32];
  logic [7:0]  burst_len [32];
  logic [2:0]  burst_size [32];
  int          burst_first [32];
  logic [63:0] beat_wdata [128];
  logic [7:0]  beat_wstrb [128];
  logic [31:0] beat_ndata [128];
  logic [3:0]  beat_nstrb [128];
  int          num_bursts;
  int          num_beats;

  int checks;
  int errors;
  int stall_left;
  bit saw_wready_low;

  localparam int wait_limit = 300;

  width_down_top dut (.*);

  always #4 clk_i = ~clk_i;

  // ------------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------------

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("test failed");
    $finish;
  endtask

  task automatic load_vectors();
    int    fd;
    int    code;
    int    t;
    string line;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] c;
    logic [63:0] d;
    fd = $fopen("width_down_input.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file");
      $display("test failed");
      $finish;
    end else begin
      num_bursts = 0;
      num_beats  = 0;
      while (!$feof(fd)) begin
        line = "";
        code = $fgets(line, fd);
        if (line.len() < 2 || line.getc(0) == "#") continue;
        if (line.getc(0) == "B") begin
          code = $sscanf(line, "B %d %h %h %h", t, a, b, c);
          burst_test[num_bursts]  = t;
          burst_addr[num_bursts]  = a[31:0];
          burst_len[num_bursts]   = b[7:0];
          burst_size[num_bursts]  = c[2:0];
          burst_first[num_bursts] = num_beats;
          num_bursts++;
        end else if (line.getc(0) == "D") begin
          code = $sscanf(line, "D %h %h %h %h", a, b, c, d);
          beat_wdata[num_beats] = a;
          beat_wstrb[num_beats] = b[7:0];
          beat_ndata[num_beats] = c[31:0];
          beat_nstrb[num_beats] = d[3:0];
          num_beats++;
        end
      end
      $fclose(fd);
    end
  endtask

  // ------------------------------------------------------------------------
  // Drivers and monitors
  // ------------------------------------------------------------------------

  task automatic drive_cmds(input int t);
    int cycles;
    for (int i = 0; i < num_bursts; i++) begin
      if (burst_test[i] != t) continue;
      s_aw_valid = 1'b1;
      s_aw_addr  = burst_addr[i];
      s_aw_len   = burst_len[i];
      s_aw_size  = burst_size[i];
      cycles = 0;
      while (1) begin
        @(posedge clk_i);
        if (s_aw_ready) break;
        cycles++;
        if (cycles > wait_limit) abort_on_timeout("s_aw_ready");
      end
      #1;
      s_aw_valid = 1'b0;
    end
  endtask

  task automatic drive_data(input int t);
    int cycles;
    for (int i = 0; i < num_bursts; i++) begin
      if (burst_test[i] != t) continue;
      for (int k = 0; k <= int'(burst_len[i]); k++) begin
        s_w_valid = 1'b1;
        s_w_data  = beat_wdata[burst_first[i] + k];
        s_w_strb  = beat_wstrb[burst_first[i] + k];
        s_w_last  = (k == int'(burst_len[i]));
        cycles = 0;
        while (1) begin
          @(posedge clk_i);
          if (s_w_ready) break;
          cycles++;
          if (cycles > wait_limit) abort_on_timeout("s_w_ready");
        end
        #1;
        s_w_valid = 1'b0;
      end
    end
  endtask

  task automatic watch_aw(input int t);
    int cycles;
    for (int i = 0; i < num_bursts; i++) begin
      if (burst_test[i] != t) continue;
      cycles = 0;
      while (1) begin
        @(posedge clk_i);
        if (m_aw_valid && m_aw_ready) break;
        cycles++;
        if (cycles > wait_limit) abort_on_timeout("an m_aw transfer");
      end
      check_value("m_aw_addr", m_aw_addr, burst_addr[i]);
      check_value("m_aw_len", m_aw_len, burst_len[i]);
      check_value("m_aw_size", m_aw_size, burst_size[i]);
    end
  endtask

  task automatic watch_w(input int t);
    int cycles;
    for (int i = 0; i < num_bursts; i++) begin
      if (burst_test[i] != t) continue;
      for (int k = 0; k <= int'(burst_len[i]); k++) begin
        cycles = 0;
        while (1) begin
          @(posedge clk_i);
          if (m_w_valid && m_w_ready) break;
          cycles++;
          if (cycles > wait_limit) abort_on_timeout("an m_w transfer");
        end
        check_value("m_w_data", m_w_data, beat_ndata[burst_first[i] + k]);
        check_value("m_w_strb", m_w_strb, beat_nstrb[burst_first[i] + k]);
        check_value("m_w_last", m_w_last, k == int'(burst_len[i]));
      end
    end
  endtask

  // Random back-pressure on both downstream channels with an optional stall
  initial begin
    void'($urandom(30141));
    m_aw_ready = 1'b0;
    m_w_ready  = 1'b0;
    forever begin
      @(posedge clk_i);
      if (stall_left > 0 && s_w_valid && !s_w_ready) saw_wready_low = 1'b1;
      #1;
      m_aw_ready = ($urandom % 4) != 0;
      if (stall_left > 0) begin
        m_w_ready = 1'b0;
        stall_left--;
      end else begin
        m_w_ready = ($urandom % 4) != 0;
      end
    end
  end

  task automatic run_test(input int t, input string name);
    int errs_before;
    int extra;
    errs_before = errors;
    extra = 0;
    if (t == 5) stall_left = 60;
    #1;
    fork
      drive_cmds(t);
      drive_data(t);
      watch_aw(t);
      watch_w(t);
    join
    // Nothing more may come out once the expected beats are seen
    repeat (8) begin
      @(posedge clk_i);
      if (m_w_valid) extra++;
    end
    check_value("extra_m_w_beats", extra, 0);
    if (t == 5) check_value("s_w_ready_fell", saw_wready_low, 1);
    $display("Test %0d %s: %0d errors", t, name, errors - errs_before);
  endtask

  // ------------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------------

  initial begin
    int errs_before;
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    s_aw_valid     = 1'b0;
    s_aw_addr      = '0;
    s_aw_len       = '0;
    s_aw_size      = '0;
    s_w_valid      = 1'b0;
    s_w_data       = '0;
    s_w_strb       = '0;
    s_w_last       = 1'b0;
    checks         = 0;
    errors         = 0;
    stall_left     = 0;
    saw_wready_low = 1'b0;
    load_vectors();
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    errs_before = errors;
    @(posedge clk_i);
    check_value("m_aw_valid", m_aw_valid, 0);
    check_value("m_w_valid", m_w_valid, 0);
    check_value("s_aw_ready", s_aw_ready, 1);
    $display("Test 1 reset values: %0d errors", errors - errs_before);
    #1;

    run_test(2, "aligned word bursts");
    run_test(3, "unaligned narrow bursts");
    run_test(4, "command and last");
    run_test(5, "long stall");

    $display("Checks run %0d, failed %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== width_down_top.sv ====
module width_down_top (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // Upstream command
  input  logic                                   s_aw_valid,
  output logic                                   s_aw_ready,
  input  logic [width_pkg::addr_width_p-1:0]     s_aw_addr,
  input  logic [width_pkg::len_width_p-1:0]      s_aw_len,
  input  logic [width_pkg::size_width_p-1:0]     s_aw_size,
  // Upstream data, wide
  input  logic                                   s_w_valid,
  output logic                                   s_w_ready,
  input  logic [8*width_pkg::wide_bytes_p-1:0]   s_w_data,
  input  logic [width_pkg::wide_bytes_p-1:0]     s_w_strb,
  input  logic                                   s_w_last,
  // Downstream command
  output logic                                   m_aw_valid,
  input  logic                                   m_aw_ready,
  output logic [width_pkg::addr_width_p-1:0]     m_aw_addr,
  output logic [width_pkg::len_width_p-1:0]      m_aw_len,
  output logic [width_pkg::size_width_p-1:0]     m_aw_size,
  // Downstream data, narrow
  output logic                                   m_w_valid,
  input  logic                                   m_w_ready,
  output logic [8*width_pkg::narrow_bytes_p-1:0] m_w_data,
  output logic [width_pkg::narrow_bytes_p-1:0]   m_w_strb,
  output logic                                   m_w_last
);

  beat_push_if push_bus ();
  beat_pop_if  pop_bus ();

  burst_accept u_accept (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .s_aw_valid (s_aw_valid),
    .s_aw_ready (s_aw_ready),
    .s_aw_addr  (s_aw_addr),
    .s_aw_len   (s_aw_len),
    .s_aw_size  (s_aw_size),
    .s_w_valid  (s_w_valid),
    .s_w_ready  (s_w_ready),
    .s_w_data   (s_w_data),
    .s_w_strb   (s_w_strb),
    .s_w_last   (s_w_last),
    .m_aw_valid (m_aw_valid),
    .m_aw_ready (m_aw_ready),
    .m_aw_addr  (m_aw_addr),
    .m_aw_len   (m_aw_len),
    .m_aw_size  (m_aw_size),
    .push_port  (push_bus)
  );

  beat_fifo u_fifo (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .push_port (push_bus),
    .pop_port  (pop_bus)
  );

  lane_steer u_steer (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .pop_port  (pop_bus),
    .m_w_valid (m_w_valid),
    .m_w_ready (m_w_ready),
    .m_w_data  (m_w_data),
    .m_w_strb  (m_w_strb),
    .m_w_last  (m_w_last)
  );

endmodule

// ==== lane_steer.sv ====
module lane_steer (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  beat_pop_if.sink                               pop_port,
  output logic                                   m_w_valid,
  input  logic                                   m_w_ready,
  output logic [8*width_pkg::narrow_bytes_p-1:0] m_w_data,
  output logic [width_pkg::narrow_bytes_p-1:0]   m_w_strb,
  output logic                                   m_w_last
);
  import width_pkg::*;

  logic                        out_valid_q;
  logic [8*narrow_bytes_p-1:0] out_data_q, data_c;
  logic [narrow_bytes_p-1:0]   out_strb_q, strb_c;
  logic                        out_last_q;
  logic                        can_load, pop_fire;

  // Output register free now or freed this cycle
  assign can_load     = !out_valid_q || m_w_ready;
  assign pop_port.pop = pop_port.valid && can_load;
  assign pop_fire     = pop_port.valid && pop_port.pop;

  // ------------------------------------------------------------------------
  // Lane steering
  // ------------------------------------------------------------------------

  always_comb begin
    int w;
    int n;
    int span;
    int b;
    data_c = '0;
    strb_c = '0;
    w    = int'(pop_port.beat.addr_lo);
    n    = w % narrow_bytes_p;
    span = 1 << pop_port.beat.size;
    b    = 0;
    // Output byte o takes wide byte w + (o - n) inside the transfer span
    for (int o = 0; o < narrow_bytes_p; o++) begin
      if ((o >= n) && (o - n < span)) begin
        b = w + o - n;
        data_c[8*o +: 8] = pop_port.beat.data[8*b +: 8];
        strb_c[o]        = pop_port.beat.strb[b];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
    end else if (pop_fire) begin
      out_valid_q <= 1'b1;
    end else if (m_w_ready) begin
      out_valid_q <= 1'b0;
    end
  end

  // Payload only changes on a new beat
  always_ff @(posedge clk_i) begin
    if (pop_fire) begin
      out_data_q <= data_c;
      out_strb_q <= strb_c;
      out_last_q <= pop_port.beat.last;
    end
  end

  assign m_w_valid = out_valid_q;
  assign m_w_data  = out_data_q;
  assign m_w_strb  = out_strb_q;
  assign m_w_last  = out_last_q;

  a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (m_w_valid && !m_w_ready) |=>
      m_w_valid && $stable(m_w_data) && $stable(m_w_strb) && $stable(m_w_last));

endmodule

// ==== beat_fifo.sv ====
module beat_fifo (
  input  logic        clk_i,
  input  logic        rst_ni,
  beat_push_if.sink   push_port,
  beat_pop_if.source  pop_port
);
  import width_pkg::*;

  // ------------------------------------------------------------------------
  // Storage and pointers
  // ------------------------------------------------------------------------

  beat_t mem_q [fifo_depth_p];

  logic [ptr_width_p-1:0] wr_ptr_q, rd_ptr_q;
  logic [cnt_width_p-1:0] count_q;
  logic                   pop_fire;
  logic                   credit_q;

  assign pop_port.valid = (count_q != '0);
  assign pop_port.beat  = mem_q[rd_ptr_q];
  assign pop_fire       = pop_port.valid & pop_port.pop;

  // One credit per popped entry, a cycle later
  assign push_port.credit_return = credit_q;

  always_ff @(posedge clk_i) begin
    if (push_port.push_en) begin
      mem_q[wr_ptr_q] <= push_port.beat;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      credit_q <= pop_fire;
      // Pointers wrap naturally, depth is a power of two
      if (push_port.push_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_fire) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + cnt_width_p'(push_port.push_en) - cnt_width_p'(pop_fire);
    end
  end

  // ------------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------------

  // Credits upstream should make overflow impossible
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_port.push_en |-> count_q != cnt_width_p'(fifo_depth_p));

  a_pop_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_port.pop |-> pop_port.valid);

endmodule

// ==== burst_accept.sv ====
module burst_accept (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               s_aw_valid,
  output logic                               s_aw_ready,
  input  logic [width_pkg::addr_width_p-1:0] s_aw_addr,
  input  logic [width_pkg::len_width_p-1:0]  s_aw_len,
  input  logic [width_pkg::size_width_p-1:0] s_aw_size,
  input  logic                               s_w_valid,
  output logic                               s_w_ready,
  input  logic [8*width_pkg::wide_bytes_p-1:0] s_w_data,
  input  logic [width_pkg::wide_bytes_p-1:0] s_w_strb,
  input  logic                               s_w_last,
  output logic                               m_aw_valid,
  input  logic                               m_aw_ready,
  output logic [width_pkg::addr_width_p-1:0] m_aw_addr,
  output logic [width_pkg::len_width_p-1:0]  m_aw_len,
  output logic [width_pkg::size_width_p-1:0] m_aw_size,
  beat_push_if.push                          push_port
);
  import width_pkg::*;

  burst_state_e state_q, state_d;

  // Command held for the downstream port
  logic                    aw_valid_q;
  logic [addr_width_p-1:0] aw_addr_q;
  logic [len_width_p-1:0]  aw_len_q;
  logic [size_width_p-1:0] aw_size_q;

  // Beat tracking within the current burst
  logic [len_width_p-1:0]      remain_q;
  logic [wide_off_width_p-1:0] beat_lo_q, beat_lo_next, step;
  logic                        beats_done_q;

  logic [cnt_width_p-1:0] credit_q;
  logic                   push_q;
  beat_t                  beat_q;

  logic aw_fire, w_fire, m_aw_fire, last_c;

  assign s_aw_ready = (state_q == burst_idle);
  // The pending push has not yet been charged against the counter
  assign s_w_ready  = (state_q != burst_idle) && !beats_done_q &&
                      (credit_q > cnt_width_p'(push_q));

  assign aw_fire   = s_aw_valid & s_aw_ready;
  assign w_fire    = s_w_valid & s_w_ready;
  assign m_aw_fire = aw_valid_q & m_aw_ready;
  assign last_c    = (remain_q == '0);

  // Incrementing burst steps to the next size boundary
  assign step         = wide_off_width_p'(1) << aw_size_q;
  assign beat_lo_next = (beat_lo_q & ~(step - 1'b1)) + step;

  assign m_aw_valid = aw_valid_q;
  assign m_aw_addr  = aw_addr_q;
  assign m_aw_len   = aw_len_q;
  assign m_aw_size  = aw_size_q;

  assign push_port.push_en = push_q;
  assign push_port.beat    = beat_q;

  // ------------------------------------------------------------------------
  // Burst FSM
  // ------------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      burst_idle: begin
        if (aw_fire) state_d = burst_cmd;
      end
      burst_cmd: begin
        // Command may leave after all beats are already in
        if (m_aw_fire) begin
          state_d = (beats_done_q || (w_fire && last_c)) ? burst_idle : burst_data;
        end
      end
      burst_data: begin
        if (w_fire && last_c) state_d = burst_idle;
      end
      default: state_d = burst_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= burst_idle;
      aw_valid_q   <= 1'b0;
      beats_done_q <= 1'b0;
      push_q       <= 1'b0;
      credit_q     <= cnt_width_p'(fifo_depth_p);
    end else begin
      state_q <= state_d;
      push_q  <= w_fire;
      credit_q <= credit_q - cnt_width_p'(push_q) +
                  cnt_width_p'(push_port.credit_return);
      if (aw_fire) begin
        aw_valid_q <= 1'b1;
      end else if (m_aw_fire) begin
        aw_valid_q <= 1'b0;
      end
      if (aw_fire) begin
        beats_done_q <= 1'b0;
      end else if (w_fire && last_c) begin
        beats_done_q <= 1'b1;
      end
    end
  end

  // Command and beat payload
  always_ff @(posedge clk_i) begin
    if (aw_fire) begin
      aw_addr_q <= s_aw_addr;
      aw_len_q  <= s_aw_len;
      aw_size_q <= s_aw_size;
      remain_q  <= s_aw_len;
      beat_lo_q <= s_aw_addr[wide_off_width_p-1:0];
    end else if (w_fire) begin
      remain_q  <= remain_q - 1'b1;
      beat_lo_q <= beat_lo_next;
    end
    if (w_fire) begin
      beat_q.data    <= s_w_data;
      beat_q.strb    <= s_w_strb;
      beat_q.addr_lo <= beat_lo_q;
      beat_q.size    <= aw_size_q;
      beat_q.last    <= last_c;
    end
  end

  a_push_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_q |-> credit_q != '0);

  // Upstream last must agree with the beat count from the command
  a_last_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_fire |-> s_w_last == last_c);

  a_size_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    s_aw_valid |-> s_aw_size <= size_width_p'(max_size_p));

endmodule

// ==== width_if.sv ====
// Producer to buffer link, credit based
interface beat_push_if;
  import width_pkg::*;

  // Beat written into the buffer this cycle
  logic  push_en;
  beat_t beat;

  // One credit handed back per popped entry
  logic  credit_return;

  modport push (
    output push_en,
    output beat,
    input  credit_return
  );

  modport sink (
    input  push_en,
    input  beat,
    output credit_return
  );

endinterface

// Buffer to consumer link, valid/pop handshake
interface beat_pop_if;
  import width_pkg::*;

  logic  valid;
  beat_t beat;
  logic  pop;

  modport source (
    output valid,
    output beat,
    input  pop
  );

  modport sink (
    input  valid,
    input  beat,
    output pop
  );

endinterface

// ==== width_pkg.sv ====
package width_pkg;

  // ------------------------------------------------------------------------
  // Bus geometry
  // ------------------------------------------------------------------------

  // Byte lanes on the upstream and downstream data buses
  localparam int unsigned wide_bytes_p   = 8;
  localparam int unsigned narrow_bytes_p = 4;

  // Command field widths
  localparam int unsigned addr_width_p = 32;
  localparam int unsigned len_width_p  = 8;
  localparam int unsigned size_width_p = 3;

  // Largest legal size code, log2 of the narrow lane count
  localparam int unsigned max_size_p = $clog2(narrow_bytes_p);

  // Byte offset of an address within one wide beat
  localparam int unsigned wide_off_width_p = $clog2(wide_bytes_p);

  // Beat buffer depth, also the producer's starting credit count
  localparam int unsigned fifo_depth_p = 4;
  localparam int unsigned ptr_width_p  = $clog2(fifo_depth_p);
  localparam int unsigned cnt_width_p  = $clog2(fifo_depth_p + 1);

  // ------------------------------------------------------------------------
  // Types
  // ------------------------------------------------------------------------

  // One data beat, stamped with its address offset and size
  typedef struct packed {
    logic [8*wide_bytes_p-1:0]   data;
    logic [wide_bytes_p-1:0]     strb;
    logic [wide_off_width_p-1:0] addr_lo;
    logic [size_width_p-1:0]     size;
    logic                        last;
  } beat_t;

  typedef enum logic [1:0] {burst_idle, burst_cmd, burst_data} burst_state_e;

endpackage
